//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = tb_player_tracker
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cam_pixel_capture.sv
`timescale 1ns/1ns
`default_nettype none

module cam_pixel_capture
  import tracker_pkg::*;
#(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  wire                         clk_camera,
  input  wire                         recent_reset,
  input  wire  [CAM_BYTE_W-1:0]       cam_data_i,
  input  wire                         cam_pclk_i,
  input  wire                         cam_hsync_i,
  input  wire                         cam_vsync_i,
  output logic                        pix_valid_o,
  output logic [PIX565_W-1:0]         pix_data_o,
  output logic [$clog2(H_ACTIVE)-1:0] pix_x_o,
  output logic [$clog2(V_ACTIVE)-1:0] pix_y_o,
  output logic                        frame_end_o
);

  localparam int X_W = $clog2(H_ACTIVE);
  localparam int Y_W = $clog2(V_ACTIVE);

  // two flop synchronizer stages, s2 is the usable copy
  logic [CAM_BYTE_W-1:0] data_s1;
  logic [CAM_BYTE_W-1:0] data_s2;
  logic                  pclk_s1, pclk_s2, pclk_q;
  logic                  hsync_s1, hsync_s2, hsync_q;
  logic                  vsync_s1, vsync_s2, vsync_q;

  logic                  pclk_rise;
  logic                  hsync_fall;
  logic                  vsync_rise;

  capture_state_t        state;
  logic [CAM_BYTE_W-1:0] high_byte;
  logic [X_W-1:0]        col;
  logic [Y_W-1:0]        row;

  // ========================================
  // synchronizer and edge detect
  // ========================================

  always_ff @(posedge clk_camera) begin
    data_s1 <= cam_data_i;
    data_s2 <= data_s1;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      {pclk_s1, pclk_s2, pclk_q}    <= '0;
      {hsync_s1, hsync_s2, hsync_q} <= '0;
      {vsync_s1, vsync_s2, vsync_q} <= '0;
    end else begin
      {pclk_q, pclk_s2, pclk_s1}    <= {pclk_s2, pclk_s1, cam_pclk_i};
      {hsync_q, hsync_s2, hsync_s1} <= {hsync_s2, hsync_s1, cam_hsync_i};
      {vsync_q, vsync_s2, vsync_s1} <= {vsync_s2, vsync_s1, cam_vsync_i};
    end
  end

  assign pclk_rise  = pclk_s2 & ~pclk_q;
  assign hsync_fall = ~hsync_s2 & hsync_q;
  assign vsync_rise = vsync_s2 & ~vsync_q;

  // ========================================
  // byte pairing and coordinates
  // ========================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state       <= WAIT_HIGH;
      col         <= '0;
      row         <= '0;
      pix_valid_o <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      pix_valid_o <= 1'b0;
      frame_end_o <= vsync_rise;
      if (vsync_rise) begin
        // new frame starts at the top left corner
        state <= WAIT_HIGH;
        col   <= '0;
        row   <= '0;
      end else if (!hsync_s2) begin
        // blanking, realign on the next line
        state <= WAIT_HIGH;
        if (hsync_fall) begin
          col <= '0;
          // hold on the last row if the camera sends extra lines
          if (row != Y_W'(V_ACTIVE - 1))
            row <= row + 1'b1;
        end
      end else if (pclk_rise) begin
        if (state == WAIT_HIGH) begin
          state <= WAIT_LOW;
        end else begin
          state       <= WAIT_HIGH;
          pix_valid_o <= 1'b1;
          if (col != X_W'(H_ACTIVE - 1))
            col <= col + 1'b1;
        end
      end
    end
  end

  // pixel payload, only meaningful with pix_valid_o
  always_ff @(posedge clk_camera) begin
    if (hsync_s2 && pclk_rise) begin
      if (state == WAIT_HIGH) begin
        high_byte <= data_s2;
      end else begin
        pix_data_o <= {high_byte, data_s2};
        pix_x_o    <= col;
        pix_y_o    <= row;
      end
    end
  end

endmodule

`default_nettype wire

//--- centroid_accumulator.sv
`timescale 1ns/1ns
`default_nettype none

module centroid_accumulator
  import tracker_pkg::*;
#(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  wire  clk_camera,
  input  wire  recent_reset,
  input  wire  mask_valid_i,
  input  wire  mask_player_i,
  input  wire  [$clog2(H_ACTIVE)-1:0] mask_x_i,
  input  wire  [$clog2(V_ACTIVE)-1:0] mask_y_i,
  input  wire  frame_end_i,
  input  wire  report_busy_i,
  output logic tot_valid_o,
  output logic [$clog2(H_ACTIVE)+$clog2(H_ACTIVE*V_ACTIVE+1)-1:0] tot_x_o,
  output logic [$clog2(V_ACTIVE)+$clog2(H_ACTIVE*V_ACTIVE+1)-1:0] tot_y_o,
  output logic [$clog2(H_ACTIVE*V_ACTIVE+1)-1:0] tot_count_o
);

  localparam int X_W   = $clog2(H_ACTIVE);
  localparam int Y_W   = $clog2(V_ACTIVE);
  // pixel count can reach every pixel of the frame
  localparam int CNT_W = $clog2(H_ACTIVE * V_ACTIVE + 1);
  // a sum of at most 2^CNT_W terms each below 2^X_W
  localparam int SX_W  = X_W + CNT_W;
  localparam int SY_W  = Y_W + CNT_W;

  logic [SX_W-1:0]  sum_x;
  logic [SY_W-1:0]  sum_y;
  logic [CNT_W-1:0] count;

  logic             hand_over;

  // only a frame with player pixels is worth a report,
  // and only if the divider is free to take it
  assign hand_over = frame_end_i && (count != '0) && !report_busy_i;

  // ========================================
  // running sums over one frame
  // ========================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
    end else if (frame_end_i) begin
      // restart for the next frame, handed over or not
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
    end else if (mask_valid_i && mask_player_i) begin
      sum_x <= sum_x + SX_W'(mask_x_i);
      sum_y <= sum_y + SY_W'(mask_y_i);
      count <= count + 1'b1;
    end
  end

  // ========================================
  // frame totals
  // ========================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset)
      tot_valid_o <= 1'b0;
    else
      tot_valid_o <= hand_over;
  end

  // totals held until the next hand over
  always_ff @(posedge clk_camera) begin
    if (hand_over) begin
      tot_x_o     <= sum_x;
      tot_y_o     <= sum_y;
      tot_count_o <= count;
    end
  end

endmodule

`default_nettype wire

//--- centroid_report.sv
`timescale 1ns/1ns
`default_nettype none

module centroid_report
  import tracker_pkg::*;
#(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  wire  clk_camera,
  input  wire  recent_reset,
  input  wire  tot_valid_i,
  input  wire  [$clog2(H_ACTIVE)+$clog2(H_ACTIVE*V_ACTIVE+1)-1:0] tot_x_i,
  input  wire  [$clog2(V_ACTIVE)+$clog2(H_ACTIVE*V_ACTIVE+1)-1:0] tot_y_i,
  input  wire  [$clog2(H_ACTIVE*V_ACTIVE+1)-1:0] tot_count_i,
  input  wire  com_ack_i,
  output logic report_busy_o,
  output logic com_req_o,
  output logic [$clog2(H_ACTIVE)-1:0] com_x_o,
  output logic [$clog2(V_ACTIVE)-1:0] com_y_o
);

  localparam int X_W       = $clog2(H_ACTIVE);
  localparam int Y_W       = $clog2(V_ACTIVE);
  localparam int CNT_W     = $clog2(H_ACTIVE * V_ACTIVE + 1);
  localparam int SX_W      = X_W + CNT_W;
  localparam int SY_W      = Y_W + CNT_W;
  // one divider sized for the wider of the two sums
  localparam int DIV_W     = (SX_W > SY_W) ? SX_W : SY_W;
  localparam int BIT_CNT_W = $clog2(DIV_W);

  report_state_t        state;
  logic                 div_y;
  logic [BIT_CNT_W-1:0] bit_cnt;

  // divider datapath
  logic [DIV_W-1:0]     quo;
  logic [CNT_W-1:0]     rem;
  logic [CNT_W-1:0]     divisor;
  logic [SY_W-1:0]      y_hold;

  logic [CNT_W:0]       rem_shift;
  logic [CNT_W:0]       rem_diff;
  logic [CNT_W-1:0]     rem_next;
  logic [DIV_W-1:0]     quo_next;
  logic                 last_bit;

  // ========================================
  // restoring divide step
  // ========================================

  // dividend bits shift out of quo as quotient bits shift in
  always_comb begin
    rem_shift = {rem, quo[DIV_W-1]};
    rem_diff  = rem_shift - {1'b0, divisor};
    if (rem_shift >= {1'b0, divisor}) begin
      rem_next = rem_diff[CNT_W-1:0];
      quo_next = {quo[DIV_W-2:0], 1'b1};
    end else begin
      rem_next = rem_shift[CNT_W-1:0];
      quo_next = {quo[DIV_W-2:0], 1'b0};
    end
  end

  assign last_bit      = (bit_cnt == BIT_CNT_W'(DIV_W - 1));
  assign report_busy_o = (state != IDLE);

  // ========================================
  // sequencing and handshake
  // ========================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state     <= IDLE;
      div_y     <= 1'b0;
      bit_cnt   <= '0;
      com_req_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (tot_valid_i) begin
            // x pass first
            state   <= DIVIDE;
            div_y   <= 1'b0;
            bit_cnt <= '0;
          end
        end
        DIVIDE: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (last_bit) begin
            bit_cnt <= '0;
            div_y   <= 1'b1;
            if (div_y) begin
              // y quotient lands on this same edge
              state     <= OFFER;
              com_req_o <= 1'b1;
            end
          end
        end
        OFFER: begin
          if (com_ack_i) begin
            state     <= RELEASE;
            com_req_o <= 1'b0;
          end
        end
        RELEASE: begin
          // wait for the consumer to drop ack
          if (!com_ack_i)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // divider registers and result latches
  always_ff @(posedge clk_camera) begin
    if (state == IDLE && tot_valid_i) begin
      quo     <= DIV_W'(tot_x_i);
      rem     <= '0;
      divisor <= tot_count_i;
      y_hold  <= tot_y_i;
    end else if (state == DIVIDE) begin
      if (last_bit && !div_y) begin
        com_x_o <= quo_next[X_W-1:0];
        // reload for the y pass
        quo <= DIV_W'(y_hold);
        rem <= '0;
      end else if (last_bit) begin
        com_y_o <= quo_next[Y_W-1:0];
      end else begin
        quo <= quo_next;
        rem <= rem_next;
      end
    end
  end

endmodule

`default_nettype wire

//--- green_screen_mask.sv
`timescale 1ns/1ns
`default_nettype none

module green_screen_mask
  import tracker_pkg::*;
#(
  parameter int X_W = 11,
  parameter int Y_W = 10
) (
  input  wire                 clk_camera,
  input  wire                 recent_reset,
  input  wire                 pix_valid_i,
  input  wire  [PIX565_W-1:0] pix_data_i,
  input  wire  [X_W-1:0]      pix_x_i,
  input  wire  [Y_W-1:0]      pix_y_i,
  input  wire  [3:0]          green_lower_i,
  input  wire  [1:0]          red_upper_i,
  input  wire  [1:0]          blue_upper_i,
  output logic                mask_valid_o,
  output logic                mask_player_o,
  output logic [X_W-1:0]      mask_x_o,
  output logic [Y_W-1:0]      mask_y_o
);

  // 5:6:5 fields padded with zeros on the right
  logic [CHAN_W-1:0] red;
  logic [CHAN_W-1:0] green;
  logic [CHAN_W-1:0] blue;

  logic [CHAN_W-1:0] green_lo;
  logic [CHAN_W-1:0] red_hi;
  logic [CHAN_W-1:0] blue_hi;

  logic              is_screen;

  assign red   = {pix_data_i[15:11], 3'b000};
  assign green = {pix_data_i[10:5], 2'b00};
  assign blue  = {pix_data_i[4:0], 3'b000};

  // switch codes scaled up into channel units
  assign green_lo = CHAN_W'(green_lower_i) << THRESH_SHIFT_G;
  assign red_hi   = CHAN_W'(red_upper_i) << THRESH_SHIFT_RB;
  assign blue_hi  = CHAN_W'(blue_upper_i) << THRESH_SHIFT_RB;

  // each channel tested on its own, all bounds inclusive
  assign is_screen = (green >= green_lo) && (green <= GREEN_CEIL) &&
                     (red <= red_hi) && (blue <= blue_hi);

  // ========================================
  // one stage of registers
  // ========================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset)
      mask_valid_o <= 1'b0;
    else
      mask_valid_o <= pix_valid_i;
  end

  // coordinates ride along with the mask bit
  always_ff @(posedge clk_camera) begin
    mask_player_o <= ~is_screen;
    mask_x_o      <= pix_x_i;
    mask_y_o      <= pix_y_i;
  end

endmodule

`default_nettype wire

//--- player_tracker_sva.sv
`timescale 1ns/1ns
`default_nettype none

module player_tracker_sva #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input wire                        clk_camera,
  input wire                        recent_reset,
  input wire                        com_req_i,
  input wire                        com_ack_i,
  input wire [$clog2(H_ACTIVE)-1:0] com_x_i,
  input wire [$clog2(V_ACTIVE)-1:0] com_y_i
);

  // one sticky flag per property
  logic       hold_bad   = 1'b0;
  logic       stable_bad = 1'b0;
  logic       early_bad  = 1'b0;
  logic       reset_bad  = 1'b0;
  logic       assert_failed;
  // cycles since reset dropped, stops at 3
  logic [1:0] since_reset;

  assign assert_failed = hold_bad | stable_bad | early_bad | reset_bad;

  always_ff @(posedge clk_camera) begin
    if (recent_reset)
      since_reset <= 2'd0;
    else if (since_reset != 2'd3)
      since_reset <= since_reset + 2'd1;
  end

  // ========================================
  // four-phase handshake
  // ========================================

  // req waits for the consumer
  assert property (@(posedge clk_camera) disable iff (recent_reset)
    com_req_i && !com_ack_i |=> com_req_i)
  else begin
    hold_bad = 1'b1;
    $error("com_req_o dropped before com_ack_i");
  end

  // centroid frozen while offered
  assert property (@(posedge clk_camera) disable iff (recent_reset)
    com_req_i && $past(com_req_i) |-> $stable(com_x_i) && $stable(com_y_i))
  else begin
    stable_bad = 1'b1;
    $error("centroid changed while com_req_o was high");
  end

  // ack still high, so no fresh req yet
  assert property (@(posedge clk_camera) disable iff (recent_reset)
    !com_req_i && com_ack_i |=> !com_req_i)
  else begin
    early_bad = 1'b1;
    $error("new com_req_o before com_ack_i fell");
  end

  // quiet right after reset
  assert property (@(posedge clk_camera) disable iff (recent_reset)
    (since_reset != 2'd3) |-> !com_req_i)
  else begin
    reset_bad = 1'b1;
    $error("com_req_o high within 3 cycles of reset");
  end

endmodule

bind player_tracker_top player_tracker_sva #(
  .H_ACTIVE (H_ACTIVE),
  .V_ACTIVE (V_ACTIVE)
) i_player_tracker_sva (
  .clk_camera   (clk_camera),
  .recent_reset (recent_reset),
  .com_req_i    (com_req_o),
  .com_ack_i    (com_ack_i),
  .com_x_i      (com_x_o),
  .com_y_i      (com_y_o)
);

`default_nettype wire

//--- player_tracker_top.sv
`timescale 1ns/1ns
`default_nettype none

module player_tracker_top
  import tracker_pkg::*;
#(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  wire                         clk_camera,
  input  wire                         recent_reset,
  input  wire  [CAM_BYTE_W-1:0]       cam_data_i,
  input  wire                         cam_pclk_i,
  input  wire                         cam_hsync_i,
  input  wire                         cam_vsync_i,
  input  wire  [3:0]                  green_lower_i,
  input  wire  [1:0]                  red_upper_i,
  input  wire  [1:0]                  blue_upper_i,
  input  wire                         com_ack_i,
  output logic                        com_req_o,
  output logic [$clog2(H_ACTIVE)-1:0] com_x_o,
  output logic [$clog2(V_ACTIVE)-1:0] com_y_o
);

  localparam int X_W   = $clog2(H_ACTIVE);
  localparam int Y_W   = $clog2(V_ACTIVE);
  localparam int CNT_W = $clog2(H_ACTIVE * V_ACTIVE + 1);
  localparam int SX_W  = X_W + CNT_W;
  localparam int SY_W  = Y_W + CNT_W;

  // ========================================
  // input side
  // ========================================

  logic                pix_valid;
  logic [PIX565_W-1:0] pix_data;
  logic [X_W-1:0]      pix_x;
  logic [Y_W-1:0]      pix_y;
  logic                frame_end;

  cam_pixel_capture #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) i_cam_pixel_capture (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cam_data_i   (cam_data_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .pix_valid_o  (pix_valid),
    .pix_data_o   (pix_data),
    .pix_x_o      (pix_x),
    .pix_y_o      (pix_y),
    .frame_end_o  (frame_end)
  );

  // player mask, one cycle behind the pixel
  logic           mask_valid;
  logic           mask_player;
  logic [X_W-1:0] mask_x;
  logic [Y_W-1:0] mask_y;

  green_screen_mask #(
    .X_W (X_W),
    .Y_W (Y_W)
  ) i_green_screen_mask (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pix_valid_i   (pix_valid),
    .pix_data_i    (pix_data),
    .pix_x_i       (pix_x),
    .pix_y_i       (pix_y),
    .green_lower_i (green_lower_i),
    .red_upper_i   (red_upper_i),
    .blue_upper_i  (blue_upper_i),
    .mask_valid_o  (mask_valid),
    .mask_player_o (mask_player),
    .mask_x_o      (mask_x),
    .mask_y_o      (mask_y)
  );

  // ========================================
  // output side
  // ========================================

  logic             tot_valid;
  logic [SX_W-1:0]  tot_x;
  logic [SY_W-1:0]  tot_y;
  logic [CNT_W-1:0] tot_count;
  logic             report_busy;

  centroid_accumulator #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) i_centroid_accumulator (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .mask_valid_i  (mask_valid),
    .mask_player_i (mask_player),
    .mask_x_i      (mask_x),
    .mask_y_i      (mask_y),
    .frame_end_i   (frame_end),
    .report_busy_i (report_busy),
    .tot_valid_o   (tot_valid),
    .tot_x_o       (tot_x),
    .tot_y_o       (tot_y),
    .tot_count_o   (tot_count)
  );

  centroid_report #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) i_centroid_report (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .tot_valid_i   (tot_valid),
    .tot_x_i       (tot_x),
    .tot_y_i       (tot_y),
    .tot_count_i   (tot_count),
    .com_ack_i     (com_ack_i),
    .report_busy_o (report_busy),
    .com_req_o     (com_req_o),
    .com_x_o       (com_x_o),
    .com_y_o       (com_y_o)
  );

endmodule

`default_nettype wire

//--- tb_player_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_player_tracker
  import tracker_pkg::*;
();

  localparam int H_ACTIVE = 16;
  localparam int V_ACTIVE = 8;
  localparam int X_W      = $clog2(H_ACTIVE);
  localparam int Y_W      = $clog2(V_ACTIVE);
  localparam int SUM_W    = X_W + $clog2(H_ACTIVE * V_ACTIVE + 1);

  // camera bus timing in clk_camera cycles
  localparam int PCLK_HALF      = 2;
  localparam int HSYNC_GAP      = 4;
  localparam int VSYNC_LEN      = 4;
  localparam int LINE_CYCLES    = 1 + H_ACTIVE * 4 * PCLK_HALF + HSYNC_GAP;
  localparam int FRAME_CYCLES   = V_ACTIVE * LINE_CYCLES + 2 * VSYNC_LEN;
  localparam int NUM_FRAMES     = 19;
  localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_CYCLES;
  // generous bound on divider latency
  localparam int REPORT_WINDOW  = 4 * SUM_W + 16;

  // g 48 expands to 192, inside the screen band
  localparam logic [PIX565_W-1:0] SCREEN_GREEN = 16'h0600;
  localparam logic [PIX565_W-1:0] FULL_RED     = 16'hF800;
  // red 64 with screen green
  localparam logic [PIX565_W-1:0] MID_RED      = 16'h4600;

  logic                  clk_camera = 1'b0;
  logic                  recent_reset;
  logic [CAM_BYTE_W-1:0] cam_data_i;
  logic                  cam_pclk_i;
  logic                  cam_hsync_i;
  logic                  cam_vsync_i;
  logic [3:0]            green_lower_i;
  logic [1:0]            red_upper_i;
  logic [1:0]            blue_upper_i;
  logic                  com_ack_i;
  logic                  com_req_o;
  logic [X_W-1:0]        com_x_o;
  logic [Y_W-1:0]        com_y_o;

  // scene, full red and mid red rectangles
  int          red_x0, red_x1, red_y0, red_y1;
  int          mid_x0, mid_x1, mid_y0, mid_y1;
  bit          red_on;
  bit          mid_on;
  bit          req_expected;
  logic [15:0] lfsr_state = 16'd22574;
  int          cycle_count = 0;
  int          ack_delay;
  int          drop_delay;
  int          n;

  player_tracker_top #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) i_player_tracker_top (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_data_i    (cam_data_i),
    .cam_pclk_i    (cam_pclk_i),
    .cam_hsync_i   (cam_hsync_i),
    .cam_vsync_i   (cam_vsync_i),
    .green_lower_i (green_lower_i),
    .red_upper_i   (red_upper_i),
    .blue_upper_i  (blue_upper_i),
    .com_ack_i     (com_ack_i),
    .com_req_o     (com_req_o),
    .com_x_o       (com_x_o),
    .com_y_o       (com_y_o)
  );

  always #5 clk_camera = ~clk_camera;

  // ========================================
  // helpers
  // ========================================

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // back to 1 ns after a rising edge
  task automatic step_clock(input int cycles);
    repeat (cycles) begin
      @(posedge clk_camera);
      #1;
    end
  endtask

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    else
      return s >> 1;
  endfunction

  task automatic random_bits(input int width, output int value);
    int i;
    value = 0;
    for (i = 0; i < width; i++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic int floor_mean(input int lo, input int hi);
    int sum;
    int k;
    sum = 0;
    for (k = lo; k <= hi; k++)
      sum = sum + k;
    return sum / (hi - lo + 1);
  endfunction

  task automatic set_red_rect(input int x0, input int x1, input int y0, input int y1);
    red_x0 = x0;
    red_x1 = x1;
    red_y0 = y0;
    red_y1 = y1;
    red_on = 1'b1;
  endtask

  // corners in any order, sorted here
  task automatic place_random_rect();
    int a;
    int b;
    random_bits(X_W, a);
    random_bits(X_W, b);
    red_x0 = (a < b) ? a : b;
    red_x1 = (a < b) ? b : a;
    random_bits(Y_W, a);
    random_bits(Y_W, b);
    red_y0 = (a < b) ? a : b;
    red_y1 = (a < b) ? b : a;
    red_on = 1'b1;
  endtask

  function automatic logic [PIX565_W-1:0] pixel_at(input int x, input int y);
    if (red_on && x >= red_x0 && x <= red_x1 && y >= red_y0 && y <= red_y1)
      return FULL_RED;
    if (mid_on && x >= mid_x0 && x <= mid_x1 && y >= mid_y0 && y <= mid_y1)
      return MID_RED;
    return SCREEN_GREEN;
  endfunction

  // ========================================
  // camera bus driver
  // ========================================

  task automatic send_byte(input logic [CAM_BYTE_W-1:0] value);
    cam_data_i = value;
    cam_pclk_i = 1'b1;
    step_clock(PCLK_HALF);
    cam_pclk_i = 1'b0;
    step_clock(PCLK_HALF);
  endtask

  // lines under hsync, then a vsync pulse closes the frame
  task automatic send_frame();
    int x;
    int y;
    logic [PIX565_W-1:0] pix;
    for (y = 0; y < V_ACTIVE; y++) begin
      cam_hsync_i = 1'b1;
      step_clock(1);
      for (x = 0; x < H_ACTIVE; x++) begin
        pix = pixel_at(x, y);
        send_byte(pix[PIX565_W-1:CAM_BYTE_W]);
        send_byte(pix[CAM_BYTE_W-1:0]);
      end
      cam_hsync_i = 1'b0;
      step_clock(HSYNC_GAP);
    end
    cam_vsync_i = 1'b1;
    step_clock(VSYNC_LEN);
    cam_vsync_i = 1'b0;
    step_clock(VSYNC_LEN);
  endtask

  // ========================================
  // handshake consumer and checks
  // ========================================

  task automatic check_centroid(input int exp_x, input int exp_y);
    assert (com_req_o && int'(com_x_o) == exp_x && int'(com_y_o) == exp_y)
    else stop_with_failure($sformatf(
      "** Error at %0t ns: req=%0b x=%0d y=%0d, expected x=%0d y=%0d",
      $time, com_req_o, com_x_o, com_y_o, exp_x, exp_y));
  endtask

  // run timeout bounds this loop
  task automatic wait_for_report(input int exp_x, input int exp_y);
    while (!com_req_o)
      step_clock(1);
    check_centroid(exp_x, exp_y);
  endtask

  task automatic release_report(input int delay, input int hold);
    step_clock(delay);
    com_ack_i = 1'b1;
    while (com_req_o)
      step_clock(1);
    req_expected = 1'b0;
    step_clock(hold);
    com_ack_i = 1'b0;
    step_clock(1);
  endtask

  // req only while a frame with player pixels is outstanding
  always @(negedge clk_camera) begin
    if (!recent_reset)
      assert (!com_req_o || req_expected)
      else stop_with_failure($sformatf(
        "** Error at %0t ns: com_req_o high with no player frame pending", $time));
  end

  always @(negedge clk_camera) begin
    if (i_player_tracker_top.i_player_tracker_sva.assert_failed)
      stop_with_failure("a concurrent assertion on the handshake or reset failed");
  end

  always @(posedge clk_camera) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_with_failure("timeout, the run went past its cycle limit");
  end

  // ========================================
  // test sequence
  // ========================================

  initial begin
    recent_reset  = 1'b1;
    cam_data_i    = '0;
    cam_pclk_i    = 1'b0;
    cam_hsync_i   = 1'b0;
    cam_vsync_i   = 1'b0;
    green_lower_i = 4'd8;
    red_upper_i   = 2'd1;
    blue_upper_i  = 2'd1;
    com_ack_i     = 1'b0;
    req_expected  = 1'b0;
    red_on        = 1'b0;
    mid_on        = 1'b0;
    repeat (3) @(posedge clk_camera);
    #1;
    recent_reset = 1'b0;
    step_clock(2);

    // plain screen right after reset, no request
    send_frame();
    step_clock(REPORT_WINDOW);

    // fixed rectangle
    set_red_rect(3, 9, 2, 5);
    req_expected = 1'b1;
    send_frame();
    wait_for_report(floor_mean(3, 9), floor_mean(2, 5));
    release_report(2, 1);

    // mid red joins the screen once red_upper is 3
    red_upper_i = 2'd3;
    set_red_rect(9, 14, 1, 3);
    mid_x0 = 0;
    mid_x1 = 5;
    mid_y0 = 4;
    mid_y1 = 7;
    mid_on = 1'b1;
    req_expected = 1'b1;
    send_frame();
    wait_for_report(floor_mean(9, 14), floor_mean(1, 3));
    release_report(0, 2);
    red_upper_i = 2'd1;
    mid_on = 1'b0;

    // empty frame after a report, sums must have cleared
    red_on = 1'b0;
    send_frame();
    step_clock(REPORT_WINDOW);

    // ack held over two more frames, both dropped
    set_red_rect(1, 4, 1, 2);
    req_expected = 1'b1;
    send_frame();
    wait_for_report(floor_mean(1, 4), floor_mean(1, 2));
    set_red_rect(10, 15, 5, 7);
    send_frame();
    check_centroid(floor_mean(1, 4), floor_mean(1, 2));
    set_red_rect(6, 8, 0, 7);
    send_frame();
    check_centroid(floor_mean(1, 4), floor_mean(1, 2));

    // req drops but ack stays high over a whole frame, that frame is lost too
    step_clock(3);
    com_ack_i = 1'b1;
    while (com_req_o)
      step_clock(1);
    req_expected = 1'b0;
    set_red_rect(0, 2, 6, 7);
    send_frame();
    com_ack_i = 1'b0;
    step_clock(1);
    step_clock(REPORT_WINDOW);
    set_red_rect(12, 15, 3, 6);
    req_expected = 1'b1;
    send_frame();
    wait_for_report(floor_mean(12, 15), floor_mean(3, 6));
    release_report(1, 0);

    // random rectangles and ack timing
    for (n = 0; n < 10; n++) begin
      place_random_rect();
      random_bits(4, ack_delay);
      random_bits(2, drop_delay);
      req_expected = 1'b1;
      send_frame();
      wait_for_report(floor_mean(red_x0, red_x1), floor_mean(red_y0, red_y1));
      release_report(ack_delay, drop_delay);
    end

    step_clock(2);
    if (i_player_tracker_top.i_player_tracker_sva.assert_failed) begin
      stop_with_failure("a concurrent assertion failed near the end of the run");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tracker_pkg.sv
`default_nettype none

package tracker_pkg;

  // ========================================
  // bus and pixel widths
  // ========================================

  // one RGB565 pixel as it leaves the camera, two bytes packed
  localparam int PIX565_W = 16;
  // expanded colour channel
  localparam int CHAN_W = 8;
  // parallel camera data bus
  localparam int CAM_BYTE_W = 8;

  // ========================================
  // threshold scaling
  // ========================================

  // 4-bit green floor becomes a multiple of 16
  localparam int THRESH_SHIFT_G = 4;
  // 2-bit red and blue ceilings become multiples of 32
  localparam int THRESH_SHIFT_RB = 5;
  // green above this is treated as glare, not screen
  localparam logic [CHAN_W-1:0] GREEN_CEIL = CHAN_W'(240);

  // byte pairing on the camera bus
  typedef enum logic {
    WAIT_HIGH,
    WAIT_LOW
  } capture_state_t;

  // centroid divide and handshake sequencing
  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    OFFER,
    RELEASE
  } report_state_t;

endpackage

`default_nettype wire

//--- vlog.f
tracker_pkg.sv
cam_pixel_capture.sv
green_screen_mask.sv
centroid_accumulator.sv
centroid_report.sv
player_tracker_top.sv
player_tracker_sva.sv
tb_player_tracker.sv
